// ==== files.f ====
+incdir+bench
hdl/cpu_core_pkg.sv
hdl/cpu_isa_pkg.sv
hdl/issue_stage.sv
hdl/execute_stage.sv
hdl/alu_stage.sv
hdl/cpu_exec_slice.sv
bench/cpu_exec_slice_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_exec_slice

sources:
  - files:
      - hdl/cpu_core_pkg.sv
      - hdl/cpu_isa_pkg.sv
      - hdl/issue_stage.sv
      - hdl/execute_stage.sv
      - hdl/alu_stage.sv
      - hdl/cpu_exec_slice.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/cpu_exec_slice_tb.sv

// ==== bench/cpu_exec_slice_checks.svh ====
//****************************************************************************
// Compare tasks and instruction-driving tasks of the execute slice testbench.
// Included inside the testbench module, after its signal declarations.
//****************************************************************************
`ifndef CPU_EXEC_SLICE_CHECKS_SVH
`define CPU_EXEC_SLICE_CHECKS_SVH

task automatic compare_word(input string name, input cpu_core_pkg::word_t exp,
	input cpu_core_pkg::word_t act);
	if (act !== exp) begin
		err_count++;
		$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic compare_addr(input string name, input cpu_core_pkg::addr_t exp,
	input cpu_core_pkg::addr_t act);
	if (act !== exp) begin
		err_count++;
		$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		err_count++;
		$display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
	end
endtask

task automatic compare_reg_idx(input string name, input cpu_core_pkg::reg_idx_t exp,
	input cpu_core_pkg::reg_idx_t act);
	if (act !== exp) begin
		err_count++;
		$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
	end
endtask

// Request strobes in the order load, store, peek, poke, PC load.
task automatic check_requests(input logic [4:0] exp);
	compare_bit("load_memory", exp[4], load_memory);
	compare_bit("store_memory", exp[3], store_memory);
	compare_bit("port_rd", exp[2], port_rd);
	compare_bit("port_wr", exp[1], port_wr);
	compare_bit("load_pc", exp[0], load_pc);
endtask

function automatic cpu_core_pkg::word_t encode(input cpu_isa_pkg::ins_class_t cls,
	input logic [3:0] op, input cpu_core_pkg::reg_idx_t a, input logic [3:0] b);
	return {cls, op, a, b};
endfunction

function automatic logic strobe_level(input strobe_t sel);
	case (sel)
		S_LOAD_MEM:  return load_memory;
		S_STORE_MEM: return store_memory;
		S_PORT_RD:   return port_rd;
		S_PORT_WR:   return port_wr;
		S_LOAD_PC:   return load_pc;
		S_HALT:      return halt;
		default:     return wb_en;
	endcase
endfunction

// Polls on the falling edge, starting with the execute cycle.
task automatic wait_strobe(input strobe_t sel, input string name);
	int cycles;
	cycles = 0;
	@(negedge CLK);
	while (!strobe_level(sel) && cycles < STROBE_TIMEOUT) begin
		@(negedge CLK);
		cycles++;
	end
	if (!strobe_level(sel)) begin
		timeout_count++;
		$display("Timeout after %0d cycles waiting for %s to go high", cycles, name);
	end
endtask

// One-cycle strobe. Also tracks the expected immediate for this instruction.
task automatic issue_instr(input cpu_core_pkg::word_t ins);
	@(posedge CLK);
	instr_valid <= 1'b1;
	instr <= ins;
	@(posedge CLK);
	instr_valid <= 1'b0;
	if (prefix_pending)
		exp_imm = {prefix_bits, ins[3:0]};
	else
		exp_imm = {{12{ins[3]}}, ins[3:0]};	// Sign extended nibble.
	prefix_pending = (cpu_isa_pkg::class_of(ins) == cpu_isa_pkg::CLS_IMM);
	if (prefix_pending)
		prefix_bits = cpu_isa_pkg::prefix_of(ins);
endtask

// Full 16-bit load through an imm prefix and a reg-imm mov.
task automatic set_reg(input cpu_core_pkg::reg_idx_t idx, input cpu_core_pkg::word_t value);
	issue_instr({cpu_isa_pkg::CLS_IMM, value[15:4]});
	run_alu(encode(cpu_isa_pkg::CLS_ALU_RI, cpu_isa_pkg::ALU_MOV, idx, value[3:0]));
endtask

`endif

// ==== bench/cpu_exec_slice_tb.sv ====
//****************************************************************************
// Testbench of the CPU execute slice: drives instructions, keeps a model of
// registers, flags and interrupt enable, and checks every stage output.
//****************************************************************************
`default_nettype none
`timescale 1ns/10ps

module cpu_exec_slice_tb;

	localparam int STROBE_TIMEOUT = 8;	// Cycles.

	typedef enum {S_LOAD_MEM, S_STORE_MEM, S_PORT_RD, S_PORT_WR, S_LOAD_PC, S_HALT,
		S_WB_EN} strobe_t;

	logic CLK;
	logic RSTb;
	logic instr_valid;
	cpu_core_pkg::word_t instr;
	logic load_memory;
	logic store_memory;
	cpu_core_pkg::addr_t load_store_address;
	cpu_core_pkg::word_t memory_out;
	logic port_rd;
	logic port_wr;
	cpu_core_pkg::addr_t port_address;
	cpu_core_pkg::word_t port_out;
	logic load_pc;
	cpu_core_pkg::addr_t new_pc;
	logic halt;
	logic int_enabled;
	logic wb_en;
	cpu_core_pkg::reg_idx_t wb_reg;
	cpu_core_pkg::word_t wb_data;
	logic flag_z;
	logic flag_c;
	logic flag_s;

	// Reference model state.
	cpu_core_pkg::word_t model_regs [16];
	logic model_z;
	logic model_c;
	logic model_s;
	logic model_ie;
	logic prefix_pending;
	logic [11:0] prefix_bits;
	cpu_core_pkg::word_t exp_imm;
	int err_count;
	int timeout_count;

	cpu_exec_slice dut_i (.*);

	always #20 CLK = ~CLK;

	`include "cpu_exec_slice_checks.svh"

	// Result and flags from the ISA rules; C is borrow on subtraction.
	task automatic model_alu(input cpu_isa_pkg::alu_op_t op, input cpu_core_pkg::word_t a,
		input cpu_core_pkg::word_t b, output cpu_core_pkg::word_t res);
		logic carry;
		carry = 1'b0;
		case (op)
			cpu_isa_pkg::ALU_MOV: res = b;
			cpu_isa_pkg::ALU_ADD: {carry, res} = a + b;
			cpu_isa_pkg::ALU_ADC: {carry, res} = a + b + model_c;
			cpu_isa_pkg::ALU_SUB, cpu_isa_pkg::ALU_CMP: begin
				res = a - b;
				carry = (a < b);
			end
			cpu_isa_pkg::ALU_SBC: begin
				res = a - b - model_c;
				carry = (17'(a) < 17'(b) + model_c);
			end
			cpu_isa_pkg::ALU_AND: res = a & b;
			cpu_isa_pkg::ALU_OR:  res = a | b;
			default:              res = a ^ b;
		endcase
		if (op != cpu_isa_pkg::ALU_MOV) begin
			model_z = (res == 16'h0000);
			model_c = carry;
			model_s = res[15];
		end
	endtask

	task automatic run_alu(input cpu_core_pkg::word_t ins);
		cpu_core_pkg::reg_idx_t dest;
		cpu_core_pkg::word_t opnd_b;
		cpu_core_pkg::word_t result;
		cpu_isa_pkg::alu_op_t op;
		dest = cpu_isa_pkg::field_a(ins);
		op = cpu_isa_pkg::alu_op_of(ins);
		issue_instr(ins);
		if (cpu_isa_pkg::class_of(ins) == cpu_isa_pkg::CLS_ALU_RI)
			opnd_b = exp_imm;
		else
			opnd_b = model_regs[cpu_isa_pkg::field_b(ins)];
		model_alu(op, model_regs[dest], opnd_b, result);
		if (op != cpu_isa_pkg::ALU_CMP) begin
			wait_strobe(S_WB_EN, "wb_en");
			compare_reg_idx("wb_reg", dest, wb_reg);
			compare_word("wb_data", result, wb_data);
			model_regs[dest] = result;
		end else begin
			@(negedge CLK);
			@(negedge CLK);
			compare_bit("wb_en", 1'b0, wb_en);	// Compare writes no register.
		end
		@(negedge CLK);
		compare_bit("flag_z", model_z, flag_z);
		compare_bit("flag_c", model_c, flag_c);
		compare_bit("flag_s", model_s, flag_s);
	endtask

	task automatic test_idle(input int cycles);
		repeat (cycles) begin
			@(negedge CLK);
			check_requests(5'b00000);
			compare_bit("halt", 1'b0, halt);
			compare_bit("wb_en", 1'b0, wb_en);
			compare_bit("int_enabled", model_ie, int_enabled);
		end
	endtask

	task automatic test_alu();
		cpu_isa_pkg::alu_op_t ops [8];
		ops = '{cpu_isa_pkg::ALU_ADD, cpu_isa_pkg::ALU_ADC, cpu_isa_pkg::ALU_SUB,
			cpu_isa_pkg::ALU_SBC, cpu_isa_pkg::ALU_AND, cpu_isa_pkg::ALU_OR,
			cpu_isa_pkg::ALU_XOR, cpu_isa_pkg::ALU_CMP};
		for (int r = 1; r <= 4; r++)
			set_reg(4'(r), 16'($urandom));
		for (int k = 0; k < 16; k++)
			run_alu(encode(cpu_isa_pkg::CLS_ALU_RR, ops[k % 8], 4'(1 + k % 4),
				4'(1 + (k + 1) % 4)));
	endtask

	task automatic test_immediate();
		run_alu(encode(cpu_isa_pkg::CLS_ALU_RI, cpu_isa_pkg::ALU_MOV, 4'd5, 4'hA));
		run_alu(encode(cpu_isa_pkg::CLS_ALU_RI, cpu_isa_pkg::ALU_ADD, 4'd5, 4'h5));
		issue_instr({cpu_isa_pkg::CLS_IMM, 12'hABC});
		run_alu(encode(cpu_isa_pkg::CLS_ALU_RI, cpu_isa_pkg::ALU_XOR, 4'd5, 4'h3));
	endtask

	// Two flag sets per condition: equal operands, then a smaller A.
	task automatic test_branches();
		cpu_isa_pkg::branch_cond_t cond;
		set_reg(4'd7, 16'h0010);
		set_reg(4'd8, 16'h0020);
		for (int k = 0; k < 14; k++) begin
			cond = cpu_isa_pkg::branch_cond_t'(k / 2);
			run_alu(encode(cpu_isa_pkg::CLS_ALU_RR, cpu_isa_pkg::ALU_CMP, 4'd7,
				(k % 2) ? 4'd8 : 4'd7));
			issue_instr(encode(cpu_isa_pkg::CLS_BRANCH, cond, 4'd7, 4'h3));
			if (cpu_isa_pkg::branch_taken(cond, model_z, model_c, model_s)) begin
				wait_strobe(S_LOAD_PC, "load_pc");
				compare_addr("new_pc", model_regs[7] + exp_imm, new_pc);
			end else begin
				@(negedge CLK);
				check_requests(5'b00000);
			end
		end
	endtask

	task automatic access_check(input cpu_isa_pkg::ins_class_t cls, input logic use_prefix,
		input strobe_t sel, input string name, input logic [4:0] exp_req);
		cpu_core_pkg::addr_t addr;
		if (use_prefix)
			issue_instr({cpu_isa_pkg::CLS_IMM, 12'h012});
		issue_instr(encode(cls, 4'h0, 4'd9, 4'd10));
		wait_strobe(sel, name);
		addr = model_regs[10] + exp_imm;
		check_requests(exp_req);
		if (sel == S_LOAD_MEM || sel == S_STORE_MEM)
			compare_addr("load_store_address", addr, load_store_address);
		else
			compare_addr("port_address", addr, port_address);
		if (sel == S_STORE_MEM)
			compare_word("memory_out", model_regs[9], memory_out);
		if (sel == S_PORT_WR)
			compare_word("port_out", model_regs[9], port_out);
	endtask

	task automatic test_mem_port();
		set_reg(4'd9, 16'($urandom));
		set_reg(4'd10, 16'($urandom));
		access_check(cpu_isa_pkg::CLS_LOAD, 1'b0, S_LOAD_MEM, "load_memory", 5'b10000);
		access_check(cpu_isa_pkg::CLS_STORE, 1'b1, S_STORE_MEM, "store_memory", 5'b01000);
		access_check(cpu_isa_pkg::CLS_PEEK, 1'b0, S_PORT_RD, "port_rd", 5'b00100);
		access_check(cpu_isa_pkg::CLS_POKE, 1'b1, S_PORT_WR, "port_wr", 5'b00010);
	endtask

	// Old value in the execute cycle, new value one cycle later.
	task automatic int_flag_check(input cpu_isa_pkg::sys_op_t op, input logic next_ie);
		issue_instr(encode(cpu_isa_pkg::CLS_SYS, op, 4'd0, 4'd0));
		@(negedge CLK);
		compare_bit("int_enabled", model_ie, int_enabled);
		model_ie = next_ie;
		@(negedge CLK);
		compare_bit("int_enabled", model_ie, int_enabled);
	endtask

	task automatic test_control();
		set_reg(4'd11, 16'($urandom));
		issue_instr(encode(cpu_isa_pkg::CLS_SYS, cpu_isa_pkg::SYS_RET, 4'd11, 4'd0));
		wait_strobe(S_LOAD_PC, "load_pc");
		compare_addr("new_pc", model_regs[11], new_pc);
		issue_instr(encode(cpu_isa_pkg::CLS_SYS, cpu_isa_pkg::SYS_INT, 4'd0, 4'd5));
		wait_strobe(S_LOAD_PC, "load_pc");
		compare_addr("new_pc", 16'd5 * 2, new_pc);	// Vector table, two words each.
		int_flag_check(cpu_isa_pkg::SYS_EI, 1'b1);
		int_flag_check(cpu_isa_pkg::SYS_DI, 1'b0);
		issue_instr(encode(cpu_isa_pkg::CLS_SYS, cpu_isa_pkg::SYS_IRET, 4'd11, 4'd0));
		wait_strobe(S_LOAD_PC, "load_pc");
		compare_addr("new_pc", model_regs[11], new_pc);
		model_ie = 1'b1;
		@(negedge CLK);
		compare_bit("int_enabled", model_ie, int_enabled);
		int_flag_check(cpu_isa_pkg::SYS_DI, 1'b0);
		issue_instr(encode(cpu_isa_pkg::CLS_SYS, cpu_isa_pkg::SYS_SLEEP, 4'd0, 4'd0));
		wait_strobe(S_HALT, "halt");
		compare_bit("load_pc", 1'b0, load_pc);
	endtask

	initial begin
		void'($urandom(32'h626c_adb3));
		CLK = 1'b0;
		RSTb = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		err_count = 0;
		timeout_count = 0;
		for (int r = 0; r < 16; r++)
			model_regs[r] = '0;
		model_z = 1'b0;
		model_c = 1'b0;
		model_s = 1'b0;
		model_ie = 1'b0;
		prefix_pending = 1'b0;
		prefix_bits = '0;
		exp_imm = '0;
		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;
		test_idle(3);
		test_alu();
		test_immediate();
		test_branches();
		test_mem_port();
		test_control();
		test_idle(4);	// Quiet bus after the last instruction.
		$display("Checks done: %0d wrong values, %0d timeouts", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/cpu_exec_slice.sv ====
//****************************************************************************
// Execute slice of the 16-bit CPU: issue, execute and ALU stages wired
// between the instruction strobe and the memory, port and PC outputs.
//****************************************************************************
`default_nettype none
`timescale 1ns/10ps

module cpu_exec_slice (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic instr_valid,
	input wire cpu_core_pkg::word_t instr,
	output logic load_memory,
	output logic store_memory,
	output cpu_core_pkg::addr_t load_store_address,
	output cpu_core_pkg::word_t memory_out,
	output logic port_rd,
	output logic port_wr,
	output cpu_core_pkg::addr_t port_address,
	output cpu_core_pkg::word_t port_out,
	output logic load_pc,
	output cpu_core_pkg::addr_t new_pc,
	output logic halt,
	output logic int_enabled,
	output logic wb_en,
	output cpu_core_pkg::reg_idx_t wb_reg,
	output cpu_core_pkg::word_t wb_data,
	output logic flag_z,
	output logic flag_c,
	output logic flag_s
);

	cpu_core_pkg::word_t ex_instr;
	cpu_core_pkg::word_t reg_a;
	cpu_core_pkg::word_t reg_b;
	cpu_core_pkg::word_t imm_reg;
	logic is_executing;

	logic alu_valid;
	cpu_isa_pkg::alu_op_t alu_op;
	cpu_core_pkg::word_t alu_a;
	cpu_core_pkg::word_t alu_b;
	cpu_core_pkg::reg_idx_t alu_dest;

	issue_stage issue_i (
		.CLK(CLK), .RSTb(RSTb),
		.instr_valid(instr_valid), .instr(instr),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.ex_instr(ex_instr), .reg_a(reg_a), .reg_b(reg_b),
		.imm_reg(imm_reg), .is_executing(is_executing)
	);

	execute_stage execute_i (
		.CLK(CLK), .RSTb(RSTb),
		.ex_instr(ex_instr), .is_executing(is_executing),
		.reg_a(reg_a), .reg_b(reg_b), .imm_reg(imm_reg),
		.flag_z(flag_z), .flag_c(flag_c), .flag_s(flag_s),
		.load_memory(load_memory), .store_memory(store_memory),
		.load_store_address(load_store_address), .memory_out(memory_out),
		.port_rd(port_rd), .port_wr(port_wr),
		.port_address(port_address), .port_out(port_out),
		.load_pc(load_pc), .new_pc(new_pc),
		.int_enabled(int_enabled), .halt(halt),
		.alu_valid(alu_valid), .alu_op(alu_op),
		.alu_a(alu_a), .alu_b(alu_b), .alu_dest(alu_dest)
	);

	alu_stage alu_i (
		.CLK(CLK), .RSTb(RSTb),
		.alu_valid(alu_valid), .alu_op(alu_op),
		.alu_a(alu_a), .alu_b(alu_b), .alu_dest(alu_dest),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.flag_z(flag_z), .flag_c(flag_c), .flag_s(flag_s)
	);

endmodule

`default_nettype wire

// ==== hdl/alu_stage.sv ====
//****************************************************************************
// ALU stage: computes the registered operation, drives register
// write-back and holds the Z, C and S flags for branch conditions.
//****************************************************************************
`default_nettype none
`timescale 1ns/10ps

module alu_stage (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic alu_valid,
	input wire cpu_isa_pkg::alu_op_t alu_op,
	input wire cpu_core_pkg::word_t alu_a,
	input wire cpu_core_pkg::word_t alu_b,
	input wire cpu_core_pkg::reg_idx_t alu_dest,
	output logic wb_en,
	output cpu_core_pkg::reg_idx_t wb_reg,
	output cpu_core_pkg::word_t wb_data,
	output logic flag_z,
	output logic flag_c,
	output logic flag_s
);

	// Result word with carry (or borrow) in the top bit.
	typedef logic [16:0] carry_word_t;

	carry_word_t wide;
	carry_word_t a_ext;
	carry_word_t b_ext;
	carry_word_t c_ext;

	assign a_ext = {1'b0, alu_a};
	assign b_ext = {1'b0, alu_b};
	assign c_ext = {16'b0, flag_c};

	always_comb begin
		case (alu_op)
			cpu_isa_pkg::ALU_MOV: wide = {flag_c, alu_b};
			cpu_isa_pkg::ALU_ADD: wide = a_ext + b_ext;
			cpu_isa_pkg::ALU_ADC: wide = a_ext + b_ext + c_ext;
			cpu_isa_pkg::ALU_SUB,
			cpu_isa_pkg::ALU_CMP: wide = a_ext - b_ext;	// Top bit is borrow.
			cpu_isa_pkg::ALU_SBC: wide = a_ext - b_ext - c_ext;
			cpu_isa_pkg::ALU_AND: wide = {1'b0, alu_a & alu_b};
			cpu_isa_pkg::ALU_OR:  wide = {1'b0, alu_a | alu_b};
			cpu_isa_pkg::ALU_XOR: wide = {1'b0, alu_a ^ alu_b};
			default:              wide = b_ext;
		endcase
	end

	// Compare only touches the flags.
	assign wb_en = alu_valid && (alu_op != cpu_isa_pkg::ALU_CMP);
	assign wb_reg = alu_dest;
	assign wb_data = wide[15:0];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			flag_z <= 1'b0;
			flag_c <= 1'b0;
			flag_s <= 1'b0;
		end else if (alu_valid && alu_op != cpu_isa_pkg::ALU_MOV) begin
			flag_z <= (wide[15:0] == 16'h0000);
			flag_c <= wide[16];
			flag_s <= wide[15];
		end
	end

	// A request from the execute stage carries a fully known operation.
	request_known: assert property (@(posedge CLK) disable iff (!RSTb)
		alu_valid |-> !$isunknown({alu_op, alu_a, alu_b, alu_dest}));

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
//****************************************************************************
// Execute stage: decodes the issued instruction into memory, port, PC,
// interrupt-flag and halt actions, and registers the ALU request.
//****************************************************************************
`default_nettype none
`timescale 1ns/10ps

module execute_stage (
	input wire logic CLK,
	input wire logic RSTb,
	input wire cpu_core_pkg::word_t ex_instr,
	input wire logic is_executing,
	input wire cpu_core_pkg::word_t reg_a,
	input wire cpu_core_pkg::word_t reg_b,
	input wire cpu_core_pkg::word_t imm_reg,
	input wire logic flag_z,
	input wire logic flag_c,
	input wire logic flag_s,
	output logic load_memory,
	output logic store_memory,
	output cpu_core_pkg::addr_t load_store_address,
	output cpu_core_pkg::word_t memory_out,
	output logic port_rd,
	output logic port_wr,
	output cpu_core_pkg::addr_t port_address,
	output cpu_core_pkg::word_t port_out,
	output logic load_pc,
	output cpu_core_pkg::addr_t new_pc,
	output logic int_enabled,
	output logic halt,
	output logic alu_valid,
	output cpu_isa_pkg::alu_op_t alu_op,
	output cpu_core_pkg::word_t alu_a,
	output cpu_core_pkg::word_t alu_b,
	output cpu_core_pkg::reg_idx_t alu_dest
);

	cpu_isa_pkg::ins_class_t ins_class;
	cpu_isa_pkg::sys_op_t sys_op;
	cpu_core_pkg::addr_t eff_addr;	// Register B plus immediate.
	logic is_alu;
	logic int_set;
	logic int_clear;

	assign ins_class = cpu_isa_pkg::class_of(ex_instr);
	assign sys_op = cpu_isa_pkg::sys_op_of(ex_instr);
	assign eff_addr = reg_b + imm_reg;
	assign is_alu = (ins_class == cpu_isa_pkg::CLS_ALU_RR) ||
		(ins_class == cpu_isa_pkg::CLS_ALU_RI);

	// Load and store.
	always_comb begin
		load_memory = 1'b0;
		store_memory = 1'b0;
		load_store_address = '0;
		memory_out = '0;
		if (is_executing && ins_class == cpu_isa_pkg::CLS_LOAD) begin
			load_memory = 1'b1;
			load_store_address = eff_addr;
		end
		if (is_executing && ins_class == cpu_isa_pkg::CLS_STORE) begin
			store_memory = 1'b1;
			load_store_address = eff_addr;
			memory_out = reg_a;
		end
	end

	// Peek and poke.
	always_comb begin
		port_rd = 1'b0;
		port_wr = 1'b0;
		port_address = '0;
		port_out = '0;
		if (is_executing && ins_class == cpu_isa_pkg::CLS_PEEK) begin
			port_rd = 1'b1;
			port_address = eff_addr;
		end
		if (is_executing && ins_class == cpu_isa_pkg::CLS_POKE) begin
			port_wr = 1'b1;
			port_address = eff_addr;
			port_out = reg_a;
		end
	end

	// PC loads from branch, return and software interrupt.
	always_comb begin
		load_pc = 1'b0;
		new_pc = '0;
		if (is_executing) begin
			if (ins_class == cpu_isa_pkg::CLS_BRANCH) begin
				if (cpu_isa_pkg::branch_taken(cpu_isa_pkg::cond_of(ex_instr),
					flag_z, flag_c, flag_s)) begin
					load_pc = 1'b1;
					new_pc = reg_a + imm_reg;
				end
			end else if (ins_class == cpu_isa_pkg::CLS_SYS) begin
				if (sys_op == cpu_isa_pkg::SYS_RET || sys_op == cpu_isa_pkg::SYS_IRET) begin
					load_pc = 1'b1;
					new_pc = reg_a;
				end else if (sys_op == cpu_isa_pkg::SYS_INT) begin
					load_pc = 1'b1;
					new_pc = {11'b0, cpu_isa_pkg::vector_of(ex_instr), 1'b0};	// Two words per vector.
				end
			end
		end
	end

	// Interrupt enable and sleep.
	always_comb begin
		int_set = 1'b0;
		int_clear = 1'b0;
		halt = 1'b0;
		if (is_executing && ins_class == cpu_isa_pkg::CLS_SYS) begin
			case (sys_op)
				cpu_isa_pkg::SYS_EI, cpu_isa_pkg::SYS_IRET: int_set = 1'b1;
				cpu_isa_pkg::SYS_DI: int_clear = 1'b1;
				cpu_isa_pkg::SYS_SLEEP: halt = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			int_enabled <= 1'b0;
			alu_valid <= 1'b0;
		end else begin
			if (int_set)
				int_enabled <= 1'b1;
			else if (int_clear)
				int_enabled <= 1'b0;
			alu_valid <= is_executing && is_alu;
		end
	end

	// ALU request, held for one cycle behind alu_valid.
	always_ff @(posedge CLK) begin
		if (is_executing && is_alu) begin
			alu_op <= cpu_isa_pkg::alu_op_of(ex_instr);
			alu_a <= reg_a;
			alu_dest <= cpu_isa_pkg::field_a(ex_instr);	// Result goes back to A.
			if (ins_class == cpu_isa_pkg::CLS_ALU_RI)
				alu_b <= imm_reg;
			else
				alu_b <= reg_b;
		end
	end

	// Each executing instruction drives at most one bus request.
	one_request: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0({load_memory, store_memory, port_rd, port_wr, load_pc}));

	sleep_no_jump: assert property (@(posedge CLK) disable iff (!RSTb)
		!(halt && load_pc));

endmodule

`default_nettype wire

// ==== hdl/issue_stage.sv ====
//****************************************************************************
// Issue stage: register file, immediate prefix and the issue register
// that presents one instruction and its operands to the execute stage.
//****************************************************************************
`default_nettype none
`timescale 1ns/10ps

module issue_stage (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic instr_valid,
	input wire cpu_core_pkg::word_t instr,
	input wire logic wb_en,
	input wire cpu_core_pkg::reg_idx_t wb_reg,
	input wire cpu_core_pkg::word_t wb_data,
	output cpu_core_pkg::word_t ex_instr,
	output cpu_core_pkg::word_t reg_a,
	output cpu_core_pkg::word_t reg_b,
	output cpu_core_pkg::word_t imm_reg,
	output logic is_executing
);

	cpu_core_pkg::word_t regs [cpu_core_pkg::NUM_REGS];

	logic prefix_pending;		// Last accepted instruction was a prefix.
	logic [11:0] prefix_data;
	logic is_prefix;

	cpu_core_pkg::reg_idx_t idx_a;
	cpu_core_pkg::reg_idx_t idx_b;
	cpu_core_pkg::word_t opnd_a;
	cpu_core_pkg::word_t opnd_b;
	cpu_core_pkg::word_t imm_next;

	assign is_prefix = (cpu_isa_pkg::class_of(instr) == cpu_isa_pkg::CLS_IMM);
	assign idx_a = cpu_isa_pkg::field_a(instr);
	assign idx_b = cpu_isa_pkg::field_b(instr);

	// Write-back in the read cycle bypasses the array.
	assign opnd_a = (wb_en && wb_reg == idx_a) ? wb_data : regs[idx_a];
	assign opnd_b = (wb_en && wb_reg == idx_b) ? wb_data : regs[idx_b];

	always_comb begin
		if (prefix_pending)
			imm_next = {prefix_data, cpu_isa_pkg::imm_nibble_of(instr)};
		else
			imm_next = {{12{instr[cpu_isa_pkg::B_MSB]}}, cpu_isa_pkg::imm_nibble_of(instr)};
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < cpu_core_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_reg] <= wb_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			prefix_pending <= 1'b0;
			is_executing <= 1'b0;
		end else begin
			is_executing <= instr_valid && !is_prefix;	// Prefixes never execute.
			if (instr_valid)
				prefix_pending <= is_prefix;	// Idle cycles keep a pending prefix.
		end
	end

	always_ff @(posedge CLK) begin
		if (instr_valid && is_prefix)
			prefix_data <= cpu_isa_pkg::prefix_of(instr);
		if (instr_valid && !is_prefix) begin
			ex_instr <= instr;
			reg_a <= opnd_a;
			reg_b <= opnd_b;
			imm_reg <= imm_next;
		end
	end

	// Write-back enable comes from the ALU stage two cycles on.
	wb_en_known: assert property (@(posedge CLK) disable iff (!RSTb)
		!$isunknown(wb_en));

endmodule

`default_nettype wire

// ==== hdl/cpu_isa_pkg.sv ====
//****************************************************************************
// Instruction set of the 16-bit CPU: classes, field positions, opcodes
// and the decode helpers used by the execute stage and the bench model.
//****************************************************************************
`default_nettype none

package cpu_isa_pkg;

	// Field positions, the same for every instruction class.
	localparam int CLASS_MSB = 15;
	localparam int CLASS_LSB = 12;
	localparam int OP_MSB = 11;
	localparam int OP_LSB = 8;
	localparam int A_MSB = 7;
	localparam int A_LSB = 4;
	localparam int B_MSB = 3;
	localparam int B_LSB = 0;
	localparam int PREFIX_MSB = 11;	// Imm prefix payload is 11..0.

	typedef enum logic [3:0] {
		CLS_SYS    = 4'd0,
		CLS_IMM    = 4'd1,
		CLS_ALU_RR = 4'd2,
		CLS_ALU_RI = 4'd3,
		CLS_BRANCH = 4'd4,
		CLS_LOAD   = 4'd5,
		CLS_STORE  = 4'd6,
		CLS_PEEK   = 4'd7,
		CLS_POKE   = 4'd8
	} ins_class_t;

	typedef enum logic [3:0] {
		SYS_NOP   = 4'd0,
		SYS_SLEEP = 4'd1,
		SYS_RET   = 4'd2,
		SYS_IRET  = 4'd3,
		SYS_INT   = 4'd4,
		SYS_EI    = 4'd5,
		SYS_DI    = 4'd6
	} sys_op_t;

	typedef enum logic [3:0] {
		ALU_MOV = 4'd0,
		ALU_ADD = 4'd1,
		ALU_ADC = 4'd2,
		ALU_SUB = 4'd3,
		ALU_SBC = 4'd4,
		ALU_AND = 4'd5,
		ALU_OR  = 4'd6,
		ALU_XOR = 4'd7,
		ALU_CMP = 4'd8
	} alu_op_t;

	typedef enum logic [3:0] {
		BR_ALWAYS = 4'd0,
		BR_Z      = 4'd1,
		BR_NZ     = 4'd2,
		BR_C      = 4'd3,
		BR_NC     = 4'd4,
		BR_S      = 4'd5,
		BR_NS     = 4'd6
	} branch_cond_t;

	function automatic ins_class_t class_of(input cpu_core_pkg::word_t ins);
		return ins_class_t'(ins[CLASS_MSB:CLASS_LSB]);
	endfunction

	function automatic cpu_core_pkg::reg_idx_t field_a(input cpu_core_pkg::word_t ins);
		return ins[A_MSB:A_LSB];
	endfunction

	function automatic cpu_core_pkg::reg_idx_t field_b(input cpu_core_pkg::word_t ins);
		return ins[B_MSB:B_LSB];
	endfunction

	function automatic alu_op_t alu_op_of(input cpu_core_pkg::word_t ins);
		return alu_op_t'(ins[OP_MSB:OP_LSB]);
	endfunction

	function automatic branch_cond_t cond_of(input cpu_core_pkg::word_t ins);
		return branch_cond_t'(ins[OP_MSB:OP_LSB]);
	endfunction

	function automatic sys_op_t sys_op_of(input cpu_core_pkg::word_t ins);
		return sys_op_t'(ins[OP_MSB:OP_LSB]);
	endfunction

	// Vector and immediate nibble share the B field.
	function automatic cpu_core_pkg::vector_t vector_of(input cpu_core_pkg::word_t ins);
		return ins[B_MSB:B_LSB];
	endfunction

	function automatic logic [3:0] imm_nibble_of(input cpu_core_pkg::word_t ins);
		return ins[B_MSB:B_LSB];
	endfunction

	function automatic logic [11:0] prefix_of(input cpu_core_pkg::word_t ins);
		return ins[PREFIX_MSB:0];
	endfunction

	function automatic logic branch_taken(input branch_cond_t cond, input logic z,
		input logic c, input logic s);
		case (cond)
			BR_ALWAYS: return 1'b1;
			BR_Z:      return z;
			BR_NZ:     return !z;
			BR_C:      return c;
			BR_NC:     return !c;
			BR_S:      return s;
			BR_NS:     return !s;
			default:   return 1'b0;	// Reserved codes never branch.
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== hdl/cpu_core_pkg.sv ====
//****************************************************************************
// Datapath types of the 16-bit CPU execute slice.
// Stages and testbench refer to these by scoped name.
//****************************************************************************
`default_nettype none

package cpu_core_pkg;

	typedef logic [15:0] word_t;	// Data word.
	typedef logic [15:0] addr_t;	// Memory or port address.
	typedef logic [3:0] reg_idx_t;	// Register number.
	typedef logic [3:0] vector_t;	// Software interrupt vector.

	// Size of the register file, one word per index.
	localparam int NUM_REGS = 16;

endpackage

`default_nettype wire
